/* hw/dramPkg.sv */
`default_nettype none

package dramPkg;

	typedef logic [23:1] cpuAddr; // Word address A23..A1
	typedef logic [11:0] dramAddr; // Multiplexed RA bus
	typedef logic [9:0] refreshCount; // Refresh interval counter
	typedef logic [3:0] waitCount; // DTACK wait counter

	typedef struct packed {
		cpuAddr addr;
		logic nWe; // Low for write
		logic nAs; // Address strobe
		logic nLds; // Lower byte strobe
		logic nUds; // Upper byte strobe
	} busReq;

	typedef struct packed {
		logic ramCs; // RAM and strobe low
		logic ramCs0x; // RAM from address only
		logic romCs; // ROM read region or overlay
		logic romCs4x; // Flash write window
		logic unmapped; // Nothing answers here
	} chipSel;

	typedef struct packed {
		dramAddr ra;
		logic nRas;
		logic nCas;
		logic nLwe; // Lower byte write
		logic nUwe; // Upper byte write
		logic nOe;
	} dramPins;

	typedef struct packed {
		logic nRomOe;
		logic nRomWe;
	} romPins;

	typedef enum logic [2:0] {
		idle, // Ready for CPU or refresh
		access, // RAS low, column on the mux
		finish, // Wait for DTACK seen
		complete, // Strobe cycle done
		refRas1, // CBR refresh RAS low
		refRas2,
		precharge1, // RAS precharge after refresh
		precharge2
	} ramState;

	localparam refreshCount refreshPeriod = 10'd400; // Clocks per refresh window
	localparam refreshCount refreshReqAt = 10'd300; // Polite request from here
	localparam refreshCount refreshUrgAt = 10'd360; // Urgent from here
	localparam waitCount romWaitCycles = 4'd3;
	localparam waitCount unmappedWaitCycles = 4'd6;

endpackage

`default_nettype wire

/* hw/addrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module addrDecode (
	input wire logic CLK,
	input wire logic reset,
	input wire dramPkg::busReq req,
	input wire logic bactive,
	output dramPkg::chipSel sel
);

	logic overlay; // Boot ROM mapped at zero
	logic [3:0] region; // A23..A20
	logic lowRegion; // 0x0 to 0x3, RAM space
	logic romRegion; // 0x4
	logic flashRegion; // 0x5

	assign region = req.addr[23:20];
	assign lowRegion = region[3:2] == 2'b00;
	assign romRegion = region == 4'h4;
	assign flashRegion = region == 4'h5;

	// Overlay lets the CPU fetch its reset vectors from ROM at address zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			overlay <= 1'b1;
		end else if (bactive && romRegion) begin
			overlay <= 1'b0; // First ROM access ends it
		end
	end

	always_comb begin
		sel.ramCs0x = lowRegion && !overlay; // Address only, for refresh choice
		sel.ramCs = sel.ramCs0x && !req.nAs;
		sel.romCs = romRegion || (lowRegion && overlay);
		sel.romCs4x = flashRegion && !req.nWe; // Reads here are unmapped
		sel.unmapped = !lowRegion && !romRegion && !sel.romCs4x;
	end

	ramRomExclusive: assert property (
		@(posedge CLK) disable iff (reset)
		!(sel.ramCs && sel.romCs)
	);

endmodule

`default_nettype wire

/* hw/refreshTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module refreshTimer (
	input wire logic CLK,
	input wire logic reset,
	output logic refReq,
	output logic refUrg
);

	dramPkg::refreshCount count; // Clocks into this period
	logic wrap; // Last clock of the period

	assign wrap = count == dramPkg::refreshPeriod - 10'd1;

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0; // New refresh window
		end else begin
			count <= count + 10'd1;
		end
	end

	// Nested windows, both end at the wrap
	assign refReq = count >= dramPkg::refreshReqAt;
	assign refUrg = count >= dramPkg::refreshUrgAt; // Late part of request window

	urgInsideReq: assert property (
		@(posedge CLK) disable iff (reset)
		refUrg |-> refReq
	);

endmodule

`default_nettype wire

/* hw/busCycle.sv */
`timescale 1ns/1ps
`default_nettype none

module busCycle (
	input wire logic CLK,
	input wire logic reset,
	input wire dramPkg::busReq req,
	input wire dramPkg::chipSel sel,
	input wire logic ramReady,
	output logic bactive,
	output logic bactiveR,
	output logic nDtack
);

	dramPkg::waitCount waitCnt; // Clocks since bactive rose
	logic ramGo; // RAM can take the cycle
	logic romDone; // ROM or flash wait elapsed
	logic unmappedDone; // Unmapped wait elapsed
	logic dtackGo;

	// Strobe sync, one and two clocks
	always_ff @(posedge CLK) begin
		if (reset) begin
			bactive <= 1'b0;
			bactiveR <= 1'b0;
		end else begin
			bactive <= !req.nAs;
			bactiveR <= bactive;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || !bactive) begin
			waitCnt <= '0;
		end else if (waitCnt != '1) begin
			waitCnt <= waitCnt + 4'd1; // Saturates
		end
	end

	assign ramGo = sel.ramCs && ramReady; // Held off while refresh runs
	assign romDone = (sel.romCs || sel.romCs4x) && (waitCnt >= dramPkg::romWaitCycles);
	assign unmappedDone = sel.unmapped && (waitCnt >= dramPkg::unmappedWaitCycles);
	assign dtackGo = bactive && (ramGo || romDone || unmappedDone);

	// DTACK held low until the strobe goes away
	always_ff @(posedge CLK) begin
		if (reset) begin
			nDtack <= 1'b1;
		end else if (req.nAs) begin
			nDtack <= 1'b1; // Cycle over
		end else if (dtackGo) begin
			nDtack <= 1'b0;
		end
	end

	dtackEndsWithStrobe: assert property (
		@(posedge CLK) disable iff (reset)
		(req.nAs && $past(req.nAs)) |-> nDtack
	);

endmodule

`default_nettype wire

/* hw/dramControl.sv */
`timescale 1ns/1ps
`default_nettype none

module dramControl (
	input wire logic CLK,
	input wire logic reset,
	input wire dramPkg::busReq req,
	input wire dramPkg::chipSel sel,
	input wire logic bactive,
	input wire logic bactiveR,
	input wire logic nDtack,
	input wire logic refReq,
	input wire logic refUrg,
	output logic ramReady,
	output dramPkg::dramPins dram,
	output dramPkg::romPins rom
);

	dramPkg::ramState state; // Sequencer, also the refresh arbiter
	dramPkg::cpuAddr a; // Short alias for the mux
	dramPkg::dramAddr rowAddr;
	dramPkg::dramAddr colAddr;
	logic dtackR; // DTACK seen
	logic rasEn; // CPU may pull RAS from idle
	logic rasEl; // Column select and write gate
	logic rasRr; // RAS from rising edge
	logic rasRf; // RAS extension on falling edge
	logic nCasR;
	logic nOeR;
	logic refDone; // Refresh done in this window
	logic refReqNow;
	logic refUrgNow;
	logic toRef; // Leave idle for refresh

	always_ff @(posedge CLK) begin
		if (reset) begin
			dtackR <= 1'b0;
		end else begin
			dtackR <= !nDtack;
		end
	end

	// One refresh per window, cleared when both requests drop at the wrap
	always_ff @(posedge CLK) begin
		if (reset) begin
			refDone <= 1'b0;
		end else if (!refReq && !refUrg) begin
			refDone <= 1'b0;
		end else if (state == dramPkg::refRas1) begin
			refDone <= 1'b1;
		end
	end

	assign refReqNow = refReq && !refDone;
	assign refUrgNow = refUrg && !refDone;

	assign toRef = (refReqNow && bactive && !bactiveR && !sel.ramCs0x) // First clock, non-RAM
		|| (refUrgNow && !bactive) // Bus idle
		|| (refUrgNow && bactive && !sel.ramCs0x); // Non-RAM cycle in progress

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= dramPkg::idle;
			rasEn <= 1'b1;
			rasEl <= 1'b0;
			rasRr <= 1'b0;
			ramReady <= 1'b1;
		end else begin
			rasEl <= 1'b0; // Defaults, overridden below
			rasRr <= 1'b0;
			rasEn <= 1'b0;
			ramReady <= 1'b1;
			unique case (state)
				dramPkg::idle: begin
					if (toRef) begin
						state <= dramPkg::refRas1;
						rasRr <= 1'b1;
						ramReady <= 1'b0;
					end else if (bactive && sel.ramCs && rasEn && nDtack) begin
						state <= dramPkg::access; // Mux to column now
						rasEl <= 1'b1;
						rasRr <= 1'b1;
						rasEn <= 1'b1;
					end else begin
						rasEn <= 1'b1; // Stay ready
					end
				end
				dramPkg::access: begin
					state <= dramPkg::finish;
					rasEl <= 1'b1;
				end
				dramPkg::finish: begin
					if (dtackR) begin
						state <= dramPkg::complete;
					end
				end
				dramPkg::complete: begin
					if (refUrgNow) begin
						state <= dramPkg::refRas1; // Urgent refresh right after RAM
						rasRr <= 1'b1;
						ramReady <= 1'b0;
					end else begin
						state <= dramPkg::idle;
						rasEn <= 1'b1;
					end
				end
				dramPkg::refRas1: begin
					state <= dramPkg::refRas2;
					rasRr <= 1'b1;
					ramReady <= 1'b0;
				end
				dramPkg::refRas2: begin
					state <= dramPkg::precharge1;
					ramReady <= 1'b0;
				end
				dramPkg::precharge1: begin
					state <= dramPkg::precharge2;
					ramReady <= 1'b0;
				end
				dramPkg::precharge2: begin
					state <= dramPkg::idle;
					rasEn <= 1'b1; // Waiting CPU cycle can go
				end
			endcase
		end
	end

	// CAS on the falling edge, half a clock ahead of the next RAS change
	always_ff @(negedge CLK) begin
		if (reset) begin
			nCasR <= 1'b1;
			rasRf <= 1'b0;
		end else begin
			rasRf <= (state == dramPkg::access) || (state == dramPkg::finish && !dtackR);
			unique case (state)
				dramPkg::idle: nCasR <= !toRef; // CBR lead
				dramPkg::access: nCasR <= 1'b0;
				dramPkg::finish: nCasR <= dtackR; // Up once DTACK seen
				dramPkg::complete: nCasR <= !refUrgNow;
				dramPkg::refRas1: nCasR <= 1'b0;
				default: nCasR <= 1'b1;
			endcase
		end
	end

	// OE from strobe to DTACK seen on a read
	always_ff @(posedge CLK) begin
		if (reset) begin
			nOeR <= 1'b1;
		end else begin
			nOeR <= !(!req.nAs && req.nWe && !(bactiveR && dtackR));
		end
	end

	assign a = req.addr;
	// RA11 and RA3 carry the same bits, RA10 and RA2 share a column
	assign rowAddr = {a[19], a[17], a[15], a[18], a[14], a[13], a[12], a[11],
		a[19], a[16], a[10], a[9]};
	assign colAddr = {a[20], a[7], a[8], a[21], a[6], a[5], a[4], a[3],
		a[20], a[7], a[2], a[1]};

	assign dram = '{
		ra: rasEl ? colAddr : rowAddr, // Row until the access edge
		nRas: !((sel.ramCs && rasEn && nDtack) || rasRr || rasRf),
		nCas: nCasR,
		nLwe: !(!req.nLds && !req.nWe && rasEl),
		nUwe: !(!req.nUds && !req.nWe && rasEl),
		nOe: nOeR
	};

	assign rom = '{
		nRomOe: !(sel.romCs && !req.nAs && req.nWe),
		nRomWe: !(sel.romCs4x && !req.nAs && !req.nWe) // Flash program window
	};

	// CAS ahead of RAS only as the CBR lead into a refresh
	casUnderRas: assert property (
		@(posedge CLK) disable iff (reset)
		($fell(dram.nCas) && dram.nRas) |=> (state == dramPkg::refRas1)
	);

endmodule

`default_nettype wire

/* hw/cpuDramTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuDramTop (
	input wire logic CLK,
	input wire logic reset,
	input wire dramPkg::busReq req,
	output logic nDtack,
	output dramPkg::dramPins dram,
	output dramPkg::romPins rom
);

	dramPkg::chipSel sel; // Decoded selects
	logic bactive; // Strobe seen one clock
	logic bactiveR; // Strobe seen two clocks
	logic ramReady; // Low during refresh
	logic refReq;
	logic refUrg;

	addrDecode decode (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.bactive(bactive),
		.sel(sel)
	);

	refreshTimer refresh (
		.CLK(CLK),
		.reset(reset),
		.refReq(refReq),
		.refUrg(refUrg)
	);

	busCycle cycle (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.sel(sel),
		.ramReady(ramReady),
		.bactive(bactive),
		.bactiveR(bactiveR),
		.nDtack(nDtack)
	);

	dramControl control (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.sel(sel),
		.bactive(bactive),
		.bactiveR(bactiveR),
		.nDtack(nDtack),
		.refReq(refReq),
		.refUrg(refUrg),
		.ramReady(ramReady),
		.dram(dram),
		.rom(rom)
	);

endmodule

`default_nettype wire

/* tests/cpuDramTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuDramTb;

	localparam int testCount = 6;
	localparam int cycleLimit = testCount * (int'(dramPkg::refreshPeriod) + 50);
	localparam int busLimit = 40; // Clocks a cycle may wait for DTACK
	// Address bit A(n) feeding RA0 up to RA11
	localparam int rowSrc [12] = '{9, 10, 16, 19, 11, 12, 13, 14, 18, 15, 17, 19};
	localparam int colSrc [12] = '{1, 2, 7, 20, 3, 4, 5, 6, 21, 8, 7, 20};

	logic CLK = 1'b0;
	logic reset;
	dramPkg::busReq req;
	logic nDtack;
	dramPkg::dramPins dram;
	dramPkg::romPins rom;
	logic rasPin;
	logic casPin;
	int errors = 0;
	int cycles = 0;
	logic [15:0] lfsr = 16'd21; // Seed
	int cpuRas = 0; // RAS falls with CAS high
	int refreshes = 0; // RAS falls with CAS already low, CBR
	int casFirst = 0; // CAS falls with RAS high
	int colFalls = 0; // CAS falls under an open row
	dramPkg::dramAddr rowSeen;
	dramPkg::dramAddr colSeen;
	time refRasTime = 0; // Last refresh RAS fall
	time lastRise = 0;
	time riseBeforeCpu = 0; // RAS rise just before the last CPU RAS fall
	dramPkg::waitCount cycleWait; // Clocks from nAS to nDTACK
	dramPkg::dramPins pinsAtAck;
	dramPkg::romPins romAtAck;
	logic oeEarly; // nOe low while nDTACK still high

	cpuDramTop uut (.CLK(CLK), .reset(reset), .req(req), .nDtack(nDtack), .dram(dram), .rom(rom));

	always #20 CLK = ~CLK; // 40 ns period

	assign rasPin = dram.nRas;
	assign casPin = dram.nCas;

	// Pin monitor
	always @(negedge rasPin) begin
		if (dram.nCas) begin
			cpuRas++;
			rowSeen = dram.ra; // Row on the mux
			riseBeforeCpu = lastRise;
		end else begin
			refreshes++;
			refRasTime = $time;
		end
	end

	always @(posedge rasPin) begin
		lastRise = $time;
	end

	always @(negedge casPin) begin
		if (!dram.nRas) begin
			colFalls++;
			colSeen = dram.ra; // Column on the mux
		end else begin
			casFirst++; // CBR lead
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Run stopped after %0d clocks without finishing", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [15:0] nextLfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Galois, taps 16 14 13 11
	endfunction

	// Random A21..A1, A23..A22 zero keeps it in RAM space
	function automatic dramPkg::cpuAddr randomRamAddr();
		dramPkg::cpuAddr a;
		a = '0;
		for (int i = 1; i <= 21; i++) begin
			a[i] = lfsr[0];
			lfsr = nextLfsr(lfsr); // One step per bit
		end
		return a;
	endfunction

	function automatic dramPkg::dramAddr expectedRa(input dramPkg::cpuAddr addr, input logic col);
		dramPkg::dramAddr ra;
		for (int i = 0; i < 12; i++) begin
			ra[i] = col ? addr[colSrc[i]] : addr[rowSrc[i]];
		end
		return ra;
	endfunction

	function automatic dramPkg::cpuAddr regionAddr(input logic [3:0] region, input logic [19:1] low);
		return {region, low}; // Region is A23..A20
	endfunction

	task flagError(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task checkAddr(input string name, input dramPkg::dramAddr got, input dramPkg::dramAddr exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task checkPins(input string name, input dramPkg::dramPins got, input dramPkg::dramPins exp,
		input dramPkg::dramPins mask);
		if ((got & mask) !== (exp & mask)) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got & mask, exp & mask);
		end
	endtask

	task checkRom(input string name, input dramPkg::romPins got, input dramPkg::romPins exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task countEquals(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	task latencyAtLeast(input string name, input dramPkg::waitCount got,
		input dramPkg::waitCount minimum);
		if (got < minimum) begin
			errors++;
			$display("Fail %s got %h expected at least %h", name, got, minimum);
		end
	endtask

	// One 68000 cycle, address a clock ahead of the strobe
	task automatic runCycle(input dramPkg::cpuAddr addr, input logic nWe, input logic nLds,
		input logic nUds);
		int waited;
		logic acked;
		waited = 0;
		acked = 1'b0;
		oeEarly = 1'b0;
		@(negedge CLK);
		req.addr = addr;
		req.nWe = nWe;
		@(negedge CLK);
		req.nAs = 1'b0;
		req.nLds = nLds;
		req.nUds = nUds;
		while (!acked && waited < busLimit) begin
			@(negedge CLK);
			waited++;
			if (!nDtack) begin
				acked = 1'b1;
			end else if (!dram.nOe) begin
				oeEarly = 1'b1;
			end
		end
		cycleWait = (waited > 15) ? 4'd15 : waited[3:0];
		pinsAtAck = dram;
		romAtAck = rom;
		if (!acked) begin
			flagError("Bus cycle timed out waiting for nDTACK");
		end
		@(negedge CLK);
		req.nAs = 1'b1; // End of cycle
		req.nLds = 1'b1;
		req.nUds = 1'b1;
		@(negedge CLK);
		req.nWe = 1'b1;
		repeat (2) @(negedge CLK); // Controller back to idle
	endtask

	task busRead(input dramPkg::cpuAddr addr);
		runCycle(addr, 1'b1, 1'b0, 1'b0);
	endtask

	task busWrite(input dramPkg::cpuAddr addr, input logic nLds, input logic nUds);
		runCycle(addr, 1'b0, nLds, nUds);
	endtask

	task waitRefresh();
		int r0;
		r0 = refreshes;
		while (refreshes == r0) begin
			@(negedge CLK);
		end
	endtask

	task overlayBoot();
		int falls;
		falls = cpuRas + refreshes;
		busRead('0); // Reset vector fetch
		checkRom("rom at boot read", romAtAck, dramPkg::romPins'{nRomOe: 1'b0, nRomWe: 1'b1});
		countEquals("RAS falls at boot read", cpuRas + refreshes - falls, 0);
		busRead(regionAddr(4'h4, 19'h0)); // Ends the overlay
		falls = cpuRas;
		busRead('0);
		countEquals("RAS falls after overlay", cpuRas - falls, 1);
		checkRom("rom at RAM read", romAtAck, dramPkg::romPins'{nRomOe: 1'b1, nRomWe: 1'b1});
	endtask

	task addrMux();
		dramPkg::cpuAddr addr;
		for (int i = 0; i < 6; i++) begin
			addr = randomRamAddr();
			busRead(addr);
			checkAddr("RA row", rowSeen, expectedRa(addr, 1'b0));
			checkAddr("RA column", colSeen, expectedRa(addr, 1'b1));
		end
	endtask

	task writeRead();
		dramPkg::dramPins exp;
		dramPkg::dramPins mask;
		dramPkg::cpuAddr addr;
		logic [1:0] strobes; // nUds, nLds
		mask = '0;
		mask.nLwe = 1'b1;
		mask.nUwe = 1'b1;
		mask.nOe = 1'b1;
		for (int i = 0; i < 3; i++) begin
			strobes = i[1:0]; // Both, upper only, lower only
			addr = randomRamAddr();
			busWrite(addr, strobes[0], strobes[1]);
			exp = '1;
			exp.nLwe = strobes[0];
			exp.nUwe = strobes[1];
			checkPins("write strobes", pinsAtAck, exp, mask);
			if (oeEarly) begin
				flagError("nOe fell during a RAM write");
			end
			busRead(addr);
			exp = '1;
			exp.nOe = 1'b0;
			checkPins("read strobes", pinsAtAck, exp, mask);
			if (!oeEarly) begin
				flagError("nOe did not fall before nDTACK on a RAM read");
			end
		end
	endtask

	task idleRefresh();
		int r0;
		int c0;
		waitRefresh();
		repeat (200) @(negedge CLK); // Middle of a period
		for (int p = 0; p < 2; p++) begin
			r0 = refreshes;
			c0 = casFirst;
			repeat (dramPkg::refreshPeriod) @(negedge CLK);
			countEquals("refreshes per period", refreshes - r0, 1);
			countEquals("CAS before RAS per period", casFirst - c0, 1);
		end
	endtask

	task backPressure();
		dramPkg::cpuAddr addr;
		int r0;
		addr = randomRamAddr();
		waitRefresh(); // Urgent refresh with the bus idle
		r0 = cpuRas;
		busRead(addr);
		countEquals("RAM RAS falls after refresh", cpuRas - r0, 1);
		if (riseBeforeCpu <= refRasTime) begin
			flagError("RAM RAS fell before the refresh RAS rose");
		end
		checkAddr("RA row after refresh", rowSeen, expectedRa(addr, 1'b0));
	endtask

	task romUnmapped();
		int r0;
		int c0;
		r0 = cpuRas;
		c0 = colFalls;
		busWrite(regionAddr(4'h5, 19'h123), 1'b0, 1'b0); // Flash program window
		checkRom("rom at flash write", romAtAck, dramPkg::romPins'{nRomOe: 1'b1, nRomWe: 1'b0});
		latencyAtLeast("ROM nDTACK wait", cycleWait, dramPkg::romWaitCycles);
		busRead(regionAddr(4'h8, 19'h456));
		checkRom("rom at unmapped read", romAtAck,
			dramPkg::romPins'{nRomOe: 1'b1, nRomWe: 1'b1});
		latencyAtLeast("unmapped nDTACK wait", cycleWait, dramPkg::unmappedWaitCycles);
		countEquals("RAM RAS falls", cpuRas - r0, 0);
		countEquals("RAM CAS falls", colFalls - c0, 0);
	endtask

	initial begin
		reset = 1'b1;
		req = '{addr: '0, nWe: 1'b1, nAs: 1'b1, nLds: 1'b1, nUds: 1'b1}; // Bus idle
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		overlayBoot();
		addrMux();
		writeRead();
		idleRefresh();
		backPressure();
		romUnmapped();
		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cpuDram.f */
hw/dramPkg.sv
hw/addrDecode.sv
hw/refreshTimer.sv
hw/busCycle.sv
hw/dramControl.sv
hw/cpuDramTop.sv
tests/cpuDramTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the cpuDram testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpuDram.f --top-module cpuDramTb \
	--Mdir obj_dir -o cpuDramSim

output=$(./obj_dir/cpuDramSim)
echo "$output"

if grep -q "^Testbench passed$" <<< "$output"; then
	exit 0
else
	exit 1
fi
